//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= tb_mont_mult
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/mont_model.svh
`ifndef MONT_MODEL_SVH
`define MONT_MODEL_SVH

// bit-serial radix-2 Montgomery product a*b*2^-32 mod m for a 32-bit odd modulus
function automatic logic [31:0] mont_expected(
    input logic [31:0] a_v,
    input logic [31:0] b_v,
    input logic [31:0] m_v
);
    logic [63:0] c;
    c = '0;
    for (int i = 0; i < 32; i++) begin
        if (a_v[i]) begin
            c = c + {32'h0, b_v};
        end
        // make c even before halving
        if (c[0]) begin
            c = c + {32'h0, m_v};
        end
        c = c >> 1;
    end
    // c < 2m at this point
    if (c >= {32'h0, m_v}) begin
        c = c - {32'h0, m_v};
    end
    return c[31:0];
endfunction

// result*2^32 and a*b must agree mod m
function automatic bit mont_consistent(
    input logic [31:0] r_v,
    input logic [31:0] a_v,
    input logic [31:0] b_v,
    input logic [31:0] m_v
);
    logic [63:0] lhs;
    logic [63:0] rhs;
    lhs = {r_v, 32'h0} % {32'h0, m_v};
    rhs = ({32'h0, a_v} * {32'h0, b_v}) % {32'h0, m_v};
    return lhs == rhs;
endfunction

function automatic logic [31:0] rand_below(input logic [31:0] m_v);
    return $urandom % m_v;
endfunction

`endif

//--- bench/tb_mont_mult.sv
`default_nettype none

module tb_mont_mult;

    localparam int WIDTH      = 32;
    localparam int LIMB_WIDTH = 8;
    localparam int NUM_RANDOM = 20;
    localparam int NUM_OPS    = 4 + NUM_RANDOM + 4 + 2;
    localparam int MAX_CYCLES = 400 * NUM_OPS;
    localparam int DRIVE_DLY  = 2;

    // one modulus with m mod 4 = 1, one with m mod 4 = 3
    localparam logic [31:0] M_LOW1 = 32'hF123_4565;
    localparam logic [31:0] M_LOW3 = 32'hC0FF_EE13;

    logic             clk;
    logic             resetn;
    logic             start;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic [WIDTH-1:0] m;
    logic [WIDTH-1:0] result;
    logic             done;

    logic [WIDTH-1:0] exp_a;
    logic [WIDTH-1:0] exp_b;
    logic [WIDTH-1:0] exp_m;
    logic [WIDTH-1:0] exp_result;
    logic             in_flight;
    logic             seen_done;
    int               cycles;

    `include "mont_model.svh"

    mont_mult #(.WIDTH(WIDTH), .LIMB_WIDTH(LIMB_WIDTH)) dut0 (
        .clk(clk), .resetn(resetn), .start(start), .a(a), .b(b), .m(m),
        .result(result), .done(done)
    );

    always #20 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("Something failed");
        $display("%s", msg);
        $fatal(1, "simulation stopped at first error");
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            seen_done <= 1'b0;
        end else if (done) begin
            seen_done <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles, operations did not finish",
                                     cycles));
        end
    end

    // the first done itself brings the first real result
    a_reset_result: assert property (
        @(posedge clk) disable iff (!resetn) (!seen_done && !done) |-> (result == '0)
    ) else report_failure($sformatf("ERR result 0x%08h expected 0x00000000",
                                    $sampled(result)));

    a_no_stray_done: assert property (
        @(posedge clk) disable iff (!resetn) done |-> in_flight
    ) else report_failure("done pulsed while no operation was running");

    a_result_value: assert property (
        @(posedge clk) disable iff (!resetn) done |-> (result == exp_result)
    ) else report_failure($sformatf(
        "ERR result 0x%08h expected 0x%08h (a 0x%08h b 0x%08h m 0x%08h)",
        $sampled(result), exp_result, exp_a, exp_b, exp_m));

    a_result_below_m: assert property (
        @(posedge clk) disable iff (!resetn) done |-> (result < exp_m)
    ) else report_failure($sformatf("ERR result 0x%08h not below m 0x%08h",
                                    $sampled(result), exp_m));

    a_result_consistent: assert property (
        @(posedge clk) disable iff (!resetn)
        done |-> mont_consistent(result, exp_a, exp_b, exp_m)
    ) else report_failure($sformatf("ERR result 0x%08h fails result*2^32 = a*b mod m 0x%08h",
                                    $sampled(result), exp_m));

    a_done_single: assert property (
        @(posedge clk) disable iff (!resetn) done |=> !done
    ) else report_failure("ERR done 0x1 expected 0x0");

    // result only moves together with done
    a_result_hold: assert property (
        @(posedge clk) disable iff (!resetn) !done |-> $stable(result)
    ) else report_failure($sformatf("ERR result 0x%08h expected 0x%08h",
                                    $sampled(result), $past(result)));

    task automatic start_op(input logic [31:0] av, input logic [31:0] bv,
                            input logic [31:0] mv);
        a          = av;
        b          = bv;
        m          = mv;
        exp_a      = av;
        exp_b      = bv;
        exp_m      = mv;
        exp_result = mont_expected(av, bv, mv);
        in_flight  = 1'b1;
        start      = 1'b1;
        @(posedge clk);
        #DRIVE_DLY start = 1'b0;
    endtask

    // done is looked at once it has settled after the edge
    task automatic wait_done();
        do begin
            @(posedge clk);
            #DRIVE_DLY;
        end while (!done);
        @(posedge clk);
        #DRIVE_DLY in_flight = 1'b0;
    endtask

    task automatic run_op(input logic [31:0] av, input logic [31:0] bv,
                          input logic [31:0] mv);
        start_op(av, bv, mv);
        wait_done();
    endtask

    // second start and new inputs while busy must not matter
    task automatic run_disturbed(input logic [31:0] mv);
        logic [31:0] av;
        logic [31:0] bv;
        av = rand_below(mv);
        bv = rand_below(mv);
        start_op(av, bv, mv);
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        a     = $urandom;
        b     = $urandom;
        m     = $urandom | 32'h1;
        start = 1'b1;
        @(posedge clk);
        #DRIVE_DLY start = 1'b0;
        a = $urandom;
        wait_done();
    endtask

    initial begin
        logic [31:0] mv;
        clk        = 1'b0;
        resetn     = 1'b0;
        start      = 1'b0;
        a          = '0;
        b          = '0;
        m          = '0;
        exp_a      = '0;
        exp_b      = '0;
        exp_m      = '0;
        exp_result = '0;
        in_flight  = 1'b0;
        cycles     = 0;
        void'($urandom(32'h1e243b39));

        repeat (2) @(posedge clk);
        #DRIVE_DLY resetn = 1'b1;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;

        // fixed vectors
        run_op(32'h0, 32'h1234_5678, M_LOW1);
        run_op(32'h1, 32'h1, M_LOW1);
        run_op(32'h0, 32'h1234_5678, M_LOW3);
        run_op(32'h1, 32'h1, M_LOW3);

        // random odd moduli, back to back
        for (int i = 0; i < NUM_RANDOM; i++) begin
            mv = $urandom | 32'h1;
            run_op(rand_below(mv), rand_below(mv), mv);
        end

        // operands just below m
        run_op(M_LOW1 - 1, M_LOW1 - 1, M_LOW1);
        run_op(M_LOW3 - 1, M_LOW3 - 2, M_LOW3);
        mv = $urandom | 32'h8000_0001;
        run_op(mv - 1, mv - 1, mv);
        run_op(mv - 2, mv - 1, mv);

        // idle gap, result must hold
        repeat (20) @(posedge clk);
        #DRIVE_DLY;

        run_disturbed(M_LOW1);
        run_disturbed($urandom | 32'h1);

        repeat (3) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+bench
src/mont_pkg.sv
src/operand_store.sv
src/limb_adder.sv
src/accumulator.sv
src/mont_control.sv
src/result_stage.sv
src/mont_mult.sv
bench/tb_mont_mult.sv

//--- src/accumulator.sv
`default_nettype none

module accumulator #(
    parameter int WIDTH = 1024
) (
    input  wire                         clk,
    input  wire                         resetn,
    input  wire  mont_pkg::phase_t      phase,
    input  wire                         add_start,
    input  wire                         add_done,
    input  wire  [WIDTH+2:0]            sum,
    input  wire  [1:0]                  a_digit,
    input  wire  [1:0]                  m_low,
    input  wire  [WIDTH+2:0]            multiple,
    input  wire  [WIDTH+2:0]            b_val,
    input  wire  [WIDTH+2:0]            b2_val,
    input  wire  [WIDTH+2:0]            m_val,
    input  wire  [WIDTH+2:0]            m2_val,
    input  wire                         clear,
    output mont_pkg::mult_sel_t         mult_sel,
    output logic [WIDTH+2:0]            x,
    output logic [WIDTH+2:0]            y,
    output mont_pkg::adder_op_t         op,
    output logic                        adder_start,
    output logic                        store_3b,
    output logic                        store_3m,
    output logic [WIDTH+2:0]            c_val
);
    import mont_pkg::*;

    localparam int AW = WIDTH + 3;

    // C + 3B can reach 5m, so C keeps the full adder width
    logic [AW-1:0] c_r;
    mult_sel_t     q_sel;
    mult_sel_t     a_sel;

    // quotient digit makes C + qM divisible by four
    always_comb begin
        if (c_r[1:0] == 2'b00) begin
            q_sel = SEL_ZERO;
        end else if (c_r[1:0] == 2'b10) begin
            q_sel = SEL_2M;
        end else if (c_r[1:0] == m_low) begin
            q_sel = SEL_3M;
        end else begin
            q_sel = SEL_M;
        end
    end

    always_comb begin
        case (a_digit)
            2'd1:    a_sel = SEL_B;
            2'd2:    a_sel = SEL_2B;
            2'd3:    a_sel = SEL_3B;
            default: a_sel = SEL_ZERO;
        endcase
    end

    always_comb begin
        x        = c_r;
        y        = multiple;
        op       = OP_ADD;
        mult_sel = SEL_ZERO;
        case (phase)
            PH_PRE_3B: begin
                x = b_val;
                y = b2_val;
            end
            PH_PRE_3M: begin
                x = m_val;
                y = m2_val;
            end
            PH_ADD_B: mult_sel = a_sel;
            PH_ADD_M: mult_sel = q_sel;
            PH_FINAL: begin
                y  = m_val;
                op = OP_SUB;
            end
            default: mult_sel = SEL_ZERO;
        endcase
    end

    assign adder_start = add_start;
    assign store_3b    = add_done && (phase == PH_PRE_3B);
    assign store_3m    = add_done && (phase == PH_PRE_3M);
    assign c_val       = c_r;

    always_ff @(posedge clk) begin
        if (!resetn || clear) begin
            c_r <= '0;
        end else if (add_done) begin
            if (phase == PH_ADD_B) begin
                c_r <= sum;
            end else if (phase == PH_ADD_M) begin
                c_r <= {2'b00, sum[AW-1:2]};
            end
        end
    end

    a_exact_div: assert property (
        @(posedge clk) disable iff (!resetn)
        (add_done && phase == PH_ADD_M) |-> (sum[1:0] == 2'b00)
    ) else $error("quotient step left low bits set");

endmodule

`default_nettype wire

//--- src/limb_adder.sv
`default_nettype none

module limb_adder #(
    parameter int WIDTH      = 1024,
    parameter int LIMB_WIDTH = 64
) (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire                        add_start,
    input  wire  mont_pkg::adder_op_t  op,
    input  wire  [WIDTH+2:0]           x,
    input  wire  [WIDTH+2:0]           y,
    output logic                       add_done,
    output logic [WIDTH+2:0]           sum,
    output logic                       sign
);
    import mont_pkg::*;

    localparam int AW        = WIDTH + 3;
    localparam int NUM_LIMBS = (AW + LIMB_WIDTH - 1) / LIMB_WIDTH;
    localparam int PW        = NUM_LIMBS * LIMB_WIDTH;
    localparam int CNT_W     = $clog2(NUM_LIMBS + 1);

    logic [PW-1:0]            x_pad;
    logic [PW-1:0]            y_eff;
    logic [PW-1:0]            x_sh;
    logic [PW-1:0]            y_sh;
    logic [PW-1:0]            acc;
    logic [PW-1:0]            cur_x;
    logic [PW-1:0]            cur_y;
    logic                     cur_c;
    logic                     carry;
    logic                     busy;
    logic [CNT_W-1:0]         limb_cnt;
    logic [LIMB_WIDTH:0]      limb_sum;
    logic [PW+LIMB_WIDTH-1:0] acc_wide;

    // subtraction as x + ~y + 1
    assign x_pad = PW'(x);
    assign y_eff = (op == OP_SUB) ? ~PW'(y) : PW'(y);

    // limb 0 is taken straight from the inputs in the start cycle
    assign cur_x = add_start ? x_pad : x_sh;
    assign cur_y = add_start ? y_eff : y_sh;
    assign cur_c = add_start ? (op == OP_SUB) : carry;

    assign limb_sum = {1'b0, cur_x[LIMB_WIDTH-1:0]}
                    + {1'b0, cur_y[LIMB_WIDTH-1:0]}
                    + {{LIMB_WIDTH{1'b0}}, cur_c};

    // new limb enters at the top, the result settles towards bit 0
    assign acc_wide = {limb_sum[LIMB_WIDTH-1:0], acc};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            limb_cnt <= '0;
            carry    <= 1'b0;
            add_done <= 1'b0;
        end else begin
            add_done <= 1'b0;
            if (add_start) begin
                busy     <= (NUM_LIMBS > 1);
                limb_cnt <= CNT_W'(1);
                carry    <= limb_sum[LIMB_WIDTH];
                add_done <= (NUM_LIMBS == 1);
            end else if (busy) begin
                limb_cnt <= limb_cnt + 1'b1;
                carry    <= limb_sum[LIMB_WIDTH];
                if (limb_cnt == CNT_W'(NUM_LIMBS - 1)) begin
                    busy     <= 1'b0;
                    add_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (add_start || busy) begin
            x_sh <= cur_x >> LIMB_WIDTH;
            y_sh <= cur_y >> LIMB_WIDTH;
            acc  <= acc_wide[PW+LIMB_WIDTH-1:LIMB_WIDTH];
        end
    end

    // held until the next job starts
    assign sum  = acc[AW-1:0];
    assign sign = acc[AW-1];

    a_no_overlap: assert property (
        @(posedge clk) disable iff (!resetn) busy |-> !add_start
    ) else $error("add_start while the adder is busy");

endmodule

`default_nettype wire

//--- src/mont_control.sv
`default_nettype none

module mont_control #(
    parameter int WIDTH = 1024
) (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     start,
    input  wire                     add_done,
    output logic                    load,
    output logic                    clear,
    output mont_pkg::phase_t        phase,
    output logic                    add_start,
    output logic                    shift_a,
    output logic                    final_valid
);
    import mont_pkg::*;

    localparam int DIGITS = WIDTH / 2;
    localparam int CNT_W  = $clog2(DIGITS + 1);

    ctrl_state_t      state;
    ctrl_state_t      state_next;
    logic [CNT_W-1:0] digit_cnt;
    logic [CNT_W-1:0] cnt_next;
    logic             start_next;
    logic             last_digit;

    assign last_digit = (digit_cnt == CNT_W'(DIGITS - 1));

    always_comb begin
        state_next = state;
        cnt_next   = digit_cnt;
        start_next = 1'b0;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_next = ST_PRE_3B;
                    cnt_next   = '0;
                    start_next = 1'b1;
                end
            end
            ST_PRE_3B: begin
                if (add_done) begin
                    state_next = ST_PRE_3M;
                    start_next = 1'b1;
                end
            end
            ST_PRE_3M: begin
                if (add_done) begin
                    state_next = ST_ADD_B;
                    start_next = 1'b1;
                end
            end
            ST_ADD_B: begin
                if (add_done) begin
                    state_next = ST_ADD_M;
                    start_next = 1'b1;
                end
            end
            ST_ADD_M: begin
                if (add_done) begin
                    start_next = 1'b1;
                    if (last_digit) begin
                        state_next = ST_FINAL;
                    end else begin
                        state_next = ST_ADD_B;
                        cnt_next   = digit_cnt + 1'b1;
                    end
                end
            end
            ST_FINAL: begin
                if (add_done) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    // add_start is registered so each job begins the cycle after the C update
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            digit_cnt <= '0;
            add_start <= 1'b0;
        end else begin
            state     <= state_next;
            digit_cnt <= cnt_next;
            add_start <= start_next;
        end
    end

    // phase follows the state, final result stays selected in ST_DONE
    always_comb begin
        case (state)
            ST_PRE_3M: phase = PH_PRE_3M;
            ST_ADD_B:  phase = PH_ADD_B;
            ST_ADD_M:  phase = PH_ADD_M;
            ST_FINAL:  phase = PH_FINAL;
            ST_DONE:   phase = PH_FINAL;
            default:   phase = PH_PRE_3B;
        endcase
    end

    // start only counts when idle
    assign load        = start && (state == ST_IDLE);
    assign clear       = start && (state == ST_IDLE);
    assign shift_a     = add_done && (state == ST_ADD_M);
    assign final_valid = (state == ST_DONE);

endmodule

`default_nettype wire

//--- src/mont_mult.sv
`default_nettype none

module mont_mult #(
    parameter int WIDTH      = mont_pkg::DEFAULT_WIDTH,
    parameter int LIMB_WIDTH = mont_pkg::DEFAULT_LIMB_WIDTH
) (
    input  wire                clk,
    input  wire                resetn,
    input  wire                start,
    input  wire  [WIDTH-1:0]   a,
    input  wire  [WIDTH-1:0]   b,
    input  wire  [WIDTH-1:0]   m,
    output logic [WIDTH-1:0]   result,
    output logic               done
);
    import mont_pkg::*;

    logic             load;
    logic             clear;
    logic             add_start;
    logic             adder_start;
    logic             add_done;
    logic             shift_a;
    logic             final_valid;
    logic             store_3b;
    logic             store_3m;
    logic             sign;
    logic [1:0]       a_digit;
    logic [1:0]       m_low;
    logic [WIDTH+2:0] sum;
    logic [WIDTH+2:0] multiple;
    logic [WIDTH+2:0] b_val;
    logic [WIDTH+2:0] b2_val;
    logic [WIDTH+2:0] m_val;
    logic [WIDTH+2:0] m2_val;
    logic [WIDTH+2:0] x;
    logic [WIDTH+2:0] y;
    logic [WIDTH+2:0] c_val;
    phase_t           phase;
    mult_sel_t        mult_sel;
    adder_op_t        op;

    operand_store #(.WIDTH(WIDTH)) operand_store0 (
        .clk(clk), .resetn(resetn), .load(load), .a(a), .b(b), .m(m),
        .shift_a(shift_a), .store_3b(store_3b), .store_3m(store_3m), .sum(sum),
        .mult_sel(mult_sel), .a_digit(a_digit), .m_low(m_low), .multiple(multiple),
        .b_val(b_val), .b2_val(b2_val), .m_val(m_val), .m2_val(m2_val)
    );

    mont_control #(.WIDTH(WIDTH)) mont_control0 (
        .clk(clk), .resetn(resetn), .start(start), .add_done(add_done),
        .load(load), .clear(clear), .phase(phase), .add_start(add_start),
        .shift_a(shift_a), .final_valid(final_valid)
    );

    accumulator #(.WIDTH(WIDTH)) accumulator0 (
        .clk(clk), .resetn(resetn), .phase(phase), .add_start(add_start),
        .add_done(add_done), .sum(sum), .a_digit(a_digit), .m_low(m_low),
        .multiple(multiple), .b_val(b_val), .b2_val(b2_val), .m_val(m_val),
        .m2_val(m2_val), .clear(clear), .mult_sel(mult_sel), .x(x), .y(y),
        .op(op), .adder_start(adder_start), .store_3b(store_3b),
        .store_3m(store_3m), .c_val(c_val)
    );

    limb_adder #(.WIDTH(WIDTH), .LIMB_WIDTH(LIMB_WIDTH)) limb_adder0 (
        .clk(clk), .resetn(resetn), .add_start(adder_start), .op(op),
        .x(x), .y(y), .add_done(add_done), .sum(sum), .sign(sign)
    );

    result_stage #(.WIDTH(WIDTH)) result_stage0 (
        .clk(clk), .resetn(resetn), .final_valid(final_valid), .sum(sum),
        .sign(sign), .c_val(c_val), .result(result), .done(done)
    );

endmodule

`default_nettype wire

//--- src/mont_pkg.sv
`default_nettype none

package mont_pkg;

    // default operand and limb sizes for the top level
    localparam int DEFAULT_WIDTH      = 1024;
    localparam int DEFAULT_LIMB_WIDTH = 64;

    // multiple presented to the adder
    typedef enum logic [2:0] {
        SEL_ZERO, SEL_B, SEL_2B, SEL_3B, SEL_M, SEL_2M, SEL_3M
    } mult_sel_t;

    typedef enum logic {
        OP_ADD, OP_SUB
    } adder_op_t;

    // what the current adder job is for
    typedef enum logic [2:0] {
        PH_PRE_3B, PH_PRE_3M, PH_ADD_B, PH_ADD_M, PH_FINAL
    } phase_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_PRE_3B, ST_PRE_3M, ST_ADD_B, ST_ADD_M, ST_FINAL, ST_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/operand_store.sv
`default_nettype none

module operand_store #(
    parameter int WIDTH = 1024
) (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire                        load,
    input  wire  [WIDTH-1:0]           a,
    input  wire  [WIDTH-1:0]           b,
    input  wire  [WIDTH-1:0]           m,
    input  wire                        shift_a,
    input  wire                        store_3b,
    input  wire                        store_3m,
    input  wire  [WIDTH+2:0]           sum,
    input  wire  mont_pkg::mult_sel_t  mult_sel,
    output logic [1:0]                 a_digit,
    output logic [1:0]                 m_low,
    output logic [WIDTH+2:0]           multiple,
    output logic [WIDTH+2:0]           b_val,
    output logic [WIDTH+2:0]           b2_val,
    output logic [WIDTH+2:0]           m_val,
    output logic [WIDTH+2:0]           m2_val
);
    import mont_pkg::*;

    localparam int AW = WIDTH + 3;

    logic [WIDTH-1:0] a_sh;
    logic [WIDTH-1:0] b_r;
    logic [WIDTH-1:0] m_r;
    logic [AW-1:0]    b3_r;
    logic [AW-1:0]    m3_r;

    // operands are captured once, a then drains two bits per digit
    always_ff @(posedge clk) begin
        if (load) begin
            a_sh <= a;
            b_r  <= b;
            m_r  <= m;
        end else if (shift_a) begin
            a_sh <= a_sh >> 2;
        end
    end

    // 3B and 3M come back from the shared adder
    always_ff @(posedge clk) begin
        if (store_3b) begin
            b3_r <= sum;
        end
        if (store_3m) begin
            m3_r <= sum;
        end
    end

    assign b_val   = {3'b000, b_r};
    assign b2_val  = {2'b00, b_r, 1'b0};
    assign m_val   = {3'b000, m_r};
    assign m2_val  = {2'b00, m_r, 1'b0};
    assign a_digit = a_sh[1:0];
    assign m_low   = m_r[1:0];

    always_comb begin
        case (mult_sel)
            SEL_B:   multiple = b_val;
            SEL_2B:  multiple = b2_val;
            SEL_3B:  multiple = b3_r;
            SEL_M:   multiple = m_val;
            SEL_2M:  multiple = m2_val;
            SEL_3M:  multiple = m3_r;
            default: multiple = '0;
        endcase
    end

    // both precomputations share one adder, one job at a time
    a_one_store: assert property (
        @(posedge clk) disable iff (!resetn) !(store_3b && store_3m)
    ) else $error("store_3b and store_3m high together");

endmodule

`default_nettype wire

//--- src/result_stage.sv
`default_nettype none

module result_stage #(
    parameter int WIDTH = 1024
) (
    input  wire                clk,
    input  wire                resetn,
    input  wire                final_valid,
    input  wire  [WIDTH+2:0]   sum,
    input  wire                sign,
    input  wire  [WIDTH+2:0]   c_val,
    output logic [WIDTH-1:0]   result,
    output logic               done
);

    // C < 2m here, one subtraction of m is enough
    always_ff @(posedge clk) begin
        if (!resetn) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= final_valid;
            if (final_valid) begin
                // negative difference means C was already below m
                if (sign) begin
                    result <= c_val[WIDTH-1:0];
                end else begin
                    result <= sum[WIDTH-1:0];
                end
            end
        end
    end

    a_done_pulse: assert property (
        @(posedge clk) disable iff (!resetn) done |=> !done
    ) else $error("done high for more than one cycle");

endmodule

`default_nettype wire
